//--- rtl/fp16_pkg.sv
// binary16 format only; infinities, NaNs and overflow are not represented here
package fp16_pkg;

    localparam int FP16_W     = 16;
    localparam int FP16_EXP_W = 5;
    localparam int FP16_FRAC_W = 10;
    localparam int FP16_MANT_W = FP16_FRAC_W + 1;   // with hidden bit
    localparam int FP16_BIAS  = 15;
    localparam int FP16_EMIN  = -14;                 // true exponent of subnormals

    // packed word {sign, exponent field, fraction}
    typedef logic [FP16_W-1:0] fp16_t;

    // biased exponent field as stored
    typedef logic [FP16_EXP_W-1:0] exp_field_t;

    // fraction field without hidden bit
    typedef logic [FP16_FRAC_W-1:0] frac_t;

    // mantissa with hidden bit, zero for subnormals
    typedef logic [FP16_MANT_W-1:0] mant_t;

    // true exponent or exponent sum, two's complement
    typedef logic signed [5:0] exp_t;

endpackage

//--- rtl/fma_pkg.sv
// widths fixed for FP16 operands with radix-8 Booth and a 35-bit aligned adder
package fma_pkg;

    // Booth multiplier
    localparam int PP_ROW_W   = 24;
    localparam int PP_ROWS    = 4;
    localparam int BOOTH_STEP = 3;
    localparam int MULT_W     = 14;   // widest multiple, 4*A

    localparam int PROD_W     = 22;
    localparam int EXT_SUM_W  = 35;

    // c dominates the product beyond this exponent gap
    localparam int C_SHIFT_LIMIT = 13;
    // c mantissa sits this many bits up, lined up with the product's binary point
    localparam int C_ALIGN_POS   = 10;

    // one partial product row, two's complement
    typedef logic [PP_ROW_W-1:0] pp_row_t;

    // a Booth multiple of a's mantissa before negation
    typedef logic [MULT_W-1:0] mult_t;

    // product of two 11-bit mantissas
    typedef logic [PROD_W-1:0] prod_sum_t;

    // aligned adder and normalizer datapath
    typedef logic [EXT_SUM_W-1:0] ext_sum_t;

    // leading-zero count over ext_sum_t
    typedef logic [5:0] lz_t;

endpackage

//--- rtl/fma_stage_if.sv
// bundle is valid only when valid is high; no handshake, no back-pressure
`timescale 1ns/1ps

interface fma_stage_if
    import fp16_pkg::*;
    import fma_pkg::*;
;

    logic      valid;
    logic      sign_ab;
    exp_t      exp_ab;          // product exponent, before normalization offset
    logic      sign_c;
    exp_t      exp_c_minus_ab;  // alignment distance of c, saturated
    mant_t     mant_c;
    prod_sum_t prod_sum;

    modport src (
        output valid, sign_ab, exp_ab, sign_c, exp_c_minus_ab, mant_c, prod_sum
    );

    modport dst (
        input valid, sign_ab, exp_ab, sign_c, exp_c_minus_ab, mant_c, prod_sum
    );

endinterface

//--- rtl/fma_mul_stage.sv
// combinational; exponent gap saturates at -32, and gaps above 13 are re-encoded as 14
`timescale 1ns/1ps

module fma_mul_stage
    import fp16_pkg::*;
    import fma_pkg::*;
(
    input  logic          in_valid,
    input  fp16_t         a,
    input  fp16_t         b,
    input  fp16_t         c,
    fma_stage_if.src      bus
);

    exp_t             exp_a, exp_b, exp_c;
    mant_t            mant_a, mant_b;
    logic signed [7:0] ab_full;
    logic signed [7:0] diff_full;
    mult_t            m1, m2, m3, m4;
    logic [12:0]      b_ext;    // b mantissa with overlap zero below
    pp_row_t          rows [PP_ROWS];
    pp_row_t          s1, c1, s2, c2;
    pp_row_t          prod_full;

    function automatic exp_t true_exp(input exp_field_t field);
        if (field == '0)
            return exp_t'(FP16_EMIN);
        return exp_t'({1'b0, field}) - exp_t'(FP16_BIAS);
    endfunction

    function automatic mant_t get_mant(input fp16_t x);
        return {(x[14:10] != '0), x[FP16_FRAC_W-1:0]};   // no hidden bit for subnormal
    endfunction

    // radix-8 digit from {b[i+2], b[i+1], b[i], b[i-1]}
    function automatic pp_row_t booth_row(input logic [3:0] grp, input mult_t p1,
                                          input mult_t p2, input mult_t p3, input mult_t p4);
        mult_t   mag;
        logic    neg;
        pp_row_t row;
        neg = grp[3];
        case (grp)
            4'b0001, 4'b0010, 4'b1101, 4'b1110: mag = p1;
            4'b0011, 4'b0100, 4'b1011, 4'b1100: mag = p2;
            4'b0101, 4'b0110, 4'b1001, 4'b1010: mag = p3;
            4'b0111, 4'b1000:                   mag = p4;
            default:                            mag = '0;   // 0000 and 1111
        endcase
        row = pp_row_t'(mag);
        return neg ? (~row + pp_row_t'(1)) : row;
    endfunction

    assign exp_a  = true_exp(a[14:10]);
    assign exp_b  = true_exp(b[14:10]);
    assign exp_c  = true_exp(c[14:10]);
    assign mant_a = get_mant(a);
    assign mant_b = get_mant(b);

    assign ab_full   = 8'(exp_a) + 8'(exp_b);
    assign diff_full = 8'(exp_c) - ab_full;

    // multiples of A, 3A is the only one needing an adder
    assign m1 = mult_t'(mant_a);
    assign m2 = mult_t'({mant_a, 1'b0});
    assign m3 = m1 + m2;
    assign m4 = mult_t'({mant_a, 2'b00});

    assign b_ext = {1'b0, mant_b, 1'b0};

    always_comb begin
        for (int j = 0; j < PP_ROWS; j++) begin
            rows[j] = booth_row(b_ext[BOOTH_STEP*j +: 4], m1, m2, m3, m4)
                      << (BOOTH_STEP * j);
        end
    end

    // two carry-save levels, then one carry-propagate add
    assign s1 = rows[0] ^ rows[1] ^ rows[2];
    assign c1 = ((rows[0] & rows[1]) | (rows[1] & rows[2]) | (rows[0] & rows[2])) << 1;
    assign s2 = s1 ^ c1 ^ rows[3];
    assign c2 = ((s1 & c1) | (c1 & rows[3]) | (s1 & rows[3])) << 1;
    assign prod_full = s2 + c2;   // wraps mod 2^24, product is positive

    always_comb begin
        bus.valid    = in_valid;
        bus.sign_ab  = a[15] ^ b[15];
        bus.sign_c   = c[15];
        bus.mant_c   = get_mant(c);
        bus.prod_sum = prod_full[PROD_W-1:0];
        if (diff_full > 8'(C_SHIFT_LIMIT)) begin
            // c dominates; keep exp_ab + gap == exp_c so c can be rebuilt later
            bus.exp_c_minus_ab = exp_t'(C_SHIFT_LIMIT + 1);
            bus.exp_ab         = exp_c - exp_t'(C_SHIFT_LIMIT + 1);
        end else begin
            bus.exp_ab         = exp_t'(ab_full);
            bus.exp_c_minus_ab = (diff_full < -8'sd32) ? exp_t'(-32) : exp_t'(diff_full);
        end
    end

    always_comb begin
        if (in_valid)
            assert final (!$isunknown({a, b, c}))
                else $error("fma_mul_stage: unknown operand bits while in_valid");
    end

endmodule

//--- rtl/fma_stage_reg.sv
// data words hold their last value while valid is low
`timescale 1ns/1ps

module fma_stage_reg
    import fp16_pkg::*;
    import fma_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    fma_stage_if.dst up,
    fma_stage_if.src down
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            down.valid <= 1'b0;
        end else begin
            down.valid <= up.valid;
        end
    end

    // payload only moves with a valid bundle
    always_ff @(posedge clk) begin
        if (up.valid) begin
            down.sign_ab        <= up.sign_ab;
            down.exp_ab         <= up.exp_ab;
            down.sign_c         <= up.sign_c;
            down.exp_c_minus_ab <= up.exp_c_minus_ab;
            down.mant_c         <= up.mant_c;
            down.prod_sum       <= up.prod_sum;
        end
    end

    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(down.valid)
    ) else $error("fma_stage_reg: valid strobe unknown");

endmodule

//--- rtl/fma_add_round.sv
// RNE only; c bits shifted past bit 0 are dropped, overflow to infinity is not handled
`timescale 1ns/1ps

module fma_add_round
    import fp16_pkg::*;
    import fma_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    fma_stage_if.dst bus,
    output logic     out_valid,
    output fp16_t    result
);

    logic              c_dominates;
    logic              do_sub;
    logic [5:0]        shift_mag;
    ext_sum_t          c_ext, c_aligned;
    ext_sum_t          raw_sum, mag_sum;
    logic              neg;
    logic              sum_zero;
    logic              res_sign;
    lz_t               lz, norm_shift;
    logic signed [7:0] exp_norm, exp_res;
    ext_sum_t          norm;
    mant_t             man;
    logic              guard_bit, round_bit, sticky_bit;
    logic              round_up;
    logic [11:0]       man_rnd;
    logic signed [7:0] exp_c_true;
    fp16_t             res_next;

    function automatic lz_t count_lz(input ext_sum_t v);
        lz_t n;
        n = lz_t'(EXT_SUM_W);   // all zero
        for (int i = 0; i < EXT_SUM_W; i++) begin
            if (v[i])
                n = lz_t'(EXT_SUM_W - 1 - i);
        end
        return n;
    endfunction

    assign c_dominates = bus.exp_c_minus_ab > exp_t'(C_SHIFT_LIMIT);
    assign do_sub      = bus.sign_c ^ bus.sign_ab;
    assign shift_mag   = bus.exp_c_minus_ab[5] ? (~bus.exp_c_minus_ab + 6'd1)
                                                : bus.exp_c_minus_ab;

    assign c_ext     = ext_sum_t'(bus.mant_c) << C_ALIGN_POS;
    assign c_aligned = bus.exp_c_minus_ab[5] ? (c_ext >> shift_mag) : (c_ext << shift_mag);

    // one's complement plus carry-in for subtraction
    assign raw_sum  = (do_sub ? ~c_aligned : c_aligned) + ext_sum_t'(bus.prod_sum)
                      + ext_sum_t'(do_sub);
    assign neg      = raw_sum[EXT_SUM_W-1];
    assign mag_sum  = neg ? (~raw_sum + ext_sum_t'(1)) : raw_sum;
    assign sum_zero = (mag_sum == '0);
    // exact zero is +0 unless both terms were negative
    assign res_sign = sum_zero ? (bus.sign_ab & bus.sign_c) : (bus.sign_ab ^ neg);

    assign lz       = count_lz(mag_sum);
    assign exp_norm = 8'(bus.exp_ab) + 8'sd14 - $signed({2'b00, lz});

    always_comb begin
        if (exp_norm < 8'(FP16_EMIN)) begin
            // clamp to emin, result comes out subnormal
            norm_shift = lz_t'(8'(bus.exp_ab) + 8'sd28);
            exp_res    = 8'(FP16_EMIN);
        end else begin
            norm_shift = lz;
            exp_res    = exp_norm;
        end
    end

    assign norm       = mag_sum << norm_shift;
    assign man        = norm[34:24];
    assign guard_bit  = norm[23];
    assign round_bit  = norm[22];
    assign sticky_bit = |norm[21:0];
    assign round_up   = guard_bit & (round_bit | sticky_bit | man[0]);
    assign man_rnd    = {1'b0, man} + 12'(round_up);

    assign exp_c_true = 8'(bus.exp_ab) + 8'(bus.exp_c_minus_ab);

    always_comb begin
        if (c_dominates) begin
            res_next = {bus.sign_c,
                        bus.mant_c[10] ? exp_field_t'(exp_c_true + 8'(FP16_BIAS)) : '0,
                        bus.mant_c[FP16_FRAC_W-1:0]};
        end else if (man_rnd[11]) begin
            // mantissa rolled over, fraction bits are already zero
            res_next = {res_sign, exp_field_t'(exp_res + 8'sd1 + 8'(FP16_BIAS)),
                        man_rnd[9:0]};
        end else if (man_rnd[10]) begin
            res_next = {res_sign, exp_field_t'(exp_res + 8'(FP16_BIAS)), man_rnd[9:0]};
        end else begin
            res_next = {res_sign, exp_field_t'(0), man_rnd[9:0]};   // subnormal or zero
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= bus.valid;
            result    <= bus.valid ? res_next : '0;
        end
    end

    // a same-sign add inside the shift limit never reaches the sign bit
    a_add_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
            (bus.valid && !do_sub && !c_dominates) |-> !neg
    ) else $error("fma_add_round: aligned sum overflowed into the sign bit");

endmodule

//--- rtl/fma_fp16.sv
// fixed two-cycle latency, one issue per cycle, no stall input
`timescale 1ns/1ps

module fma_fp16
    import fp16_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    input  fp16_t a,
    input  fp16_t b,
    input  fp16_t c,
    output logic  out_valid,
    output fp16_t result
);

    fma_stage_if mul_bus ();   // combinational product bundle
    fma_stage_if reg_bus ();   // registered copy

    fma_mul_stage u_mul (
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .c        (c),
        .bus      (mul_bus.src)
    );

    fma_stage_reg u_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .up    (mul_bus.dst),
        .down  (reg_bus.src)
    );

    fma_add_round u_add (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (reg_bus.dst),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

//--- dv/fma_cases.svh
// binary16 vectors with RNE; no inf, NaN or overflow, and c never loses bits below the product LSB
`ifndef FMA_CASES_SVH
`define FMA_CASES_SVH

    // columns: a, b, c, expected a*b+c rounded once
    typedef struct packed {
        fp16_t a;
        fp16_t b;
        fp16_t c;
        fp16_t expected;
    } fma_case_t;

    localparam int NUM_CASES = 24;

    localparam logic [63:0] CASE_ROWS [NUM_CASES] = '{
        // plain fused results
        64'h3c00_3c00_3c00_4000,   // 1*1+1 = 2
        64'h4000_4200_bc00_4500,   // 2*3-1 = 5
        64'h3e00_4100_3400_4400,   // 1.5*2.5+0.25 = 4
        64'hbe00_c100_3400_4400,   // both factors negative
        64'hc000_4200_3c00_c500,   // -2*3+1 = -5
        64'h4900_4900_c000_5620,   // 10*10-2 = 98, c shifted right
        // cancellation
        64'h3c01_3c00_bc00_1400,   // leaves 2^-10
        64'h3bff_3c00_bc00_9000,   // negative remainder -2^-11
        64'h3e01_3e00_c080_1600,
        64'h3800_3800_b400_0000,   // exact zero is +0
        64'hbc00_0000_8000_8000,   // -0 plus -0
        // subnormal inputs and outputs
        64'h0001_4000_0000_0002,
        64'h1c00_1c00_0000_0100,   // 2^-16 comes out subnormal
        64'h0200_3c00_0201_0401,   // two subnormals sum to a normal
        // round to nearest even
        64'h3c00_3c00_1000_3c00,   // halfway, stays even
        64'h3c01_3c00_1000_3c02,   // halfway, up to even
        64'h3c00_3c00_1100_3c01,   // just above halfway, sticky
        64'h3c00_3c00_0c00_3c00,   // below halfway
        64'h3c01_3c01_0000_3c02,   // product bits only in sticky
        64'h3fff_3c00_1000_4000,   // mantissa rollover into exponent
        // dominant addend
        64'h3c00_3c00_7000_7000,   // gap of 13, full datapath
        64'h3c00_3c00_7400_7400,   // gap of 14
        64'h2000_2000_3c01_3c01,
        64'h2000_2000_bc01_bc01
    };

`endif

//--- dv/fma_tb.sv
// assumes a fixed two-cycle latency and in-order results; stops at the first mismatch
`timescale 1ns/1ps

module fma_tb
    import fp16_pkg::*;
;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DLY    = 2;

    `include "fma_cases.svh"

    // room for a gap before every entry plus the pipeline drain
    localparam int WATCHDOG_NS = (RESET_CYCLES + NUM_CASES * 2 + 10) * CLK_PERIOD;

    logic  clk;
    logic  rst_n;
    logic  in_valid;
    fp16_t a;
    fp16_t b;
    fp16_t c;
    logic  out_valid;
    fp16_t result;

    integer     seed = 5;
    int         issued_q [$];      // case indices in flight
    int         checked = 0;
    logic [1:0] valid_hist = '0;   // in_valid at the last two falling edges

    fma_fp16 u_fma_fp16 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .c         (c),
        .out_valid (out_valid),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_result(input fp16_t got, input fp16_t expected, input int idx);
        if (got !== expected) begin
            $display("** Error result: case %0d got 0x%h expected 0x%h", idx, got, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic check_valid(input logic got, input logic expected);
        if (got !== expected) begin
            $display("** Error out_valid: got 0x%h expected 0x%h at %0t", got, expected, $time);
            $display("Simulation finished: FAIL");
            $fatal(1, "strobe mismatch");
        end
    endtask

    task automatic issue_case(input int idx);
        fma_case_t tc;
        tc = fma_case_t'(CASE_ROWS[idx]);
        @(posedge clk);
        #DRIVE_DLY;
        in_valid = 1'b1;
        a        = tc.a;
        b        = tc.b;
        c        = tc.c;
        issued_q.push_back(idx);
    endtask

    // random operands must not leak through while in_valid is low
    task automatic idle_cycle();
        @(posedge clk);
        #DRIVE_DLY;
        in_valid = 1'b0;
        a        = fp16_t'($random(seed));
        b        = fp16_t'($random(seed));
        c        = fp16_t'($random(seed));
    endtask

    // outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        fma_case_t tc;
        int        idx;
        check_valid(out_valid, valid_hist[1]);
        valid_hist = {valid_hist[0], in_valid};
        if (out_valid) begin
            idx = issued_q.pop_front();
            tc  = fma_case_t'(CASE_ROWS[idx]);
            check_result(result, tc.expected, idx);
            checked++;
        end
    end

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        c        = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        for (int i = 0; i < NUM_CASES; i++) begin
            if (($random(seed) & 3) == 0)
                idle_cycle();   // gap, otherwise back to back
            issue_case(i);
        end
        idle_cycle();

        wait (checked == NUM_CASES);
        repeat (3) idle_cycle();   // strobe has to stay low once drained

        $display("Simulation finished: PASS");
        $finish;
    end

    initial begin
        #WATCHDOG_NS;
        $display("timeout: only %0d of %0d results came back", checked, NUM_CASES);
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- tb.f
+incdir+dv
rtl/fp16_pkg.sv
rtl/fma_pkg.sv
rtl/fma_stage_if.sv
rtl/fma_mul_stage.sv
rtl/fma_stage_reg.sv
rtl/fma_add_round.sv
rtl/fma_fp16.sv
dv/fma_tb.sv

//--- run.sh
#!/bin/sh
# builds the FMA testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module fma_tb -f tb.f -o fma_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/fma_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^Simulation finished: PASS$"; then
    exit 0
fi
echo "pass message not found"
exit 1
